// File: Makefile
# Verilator build and run for the SDRAM controller testbench

VERILATOR ?= verilator
TOP ?= sdram_ctrl_tb
FILELIST ?= compile.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/sdram_checker.sv
// SDRAM controller checker

`timescale 1ns/100ps
`default_nettype none

module sdram_checker
  (
  input logic clk,
  input logic reset_l,
  input logic req,
  input logic wr,
  input logic [21:0] addr,
  input logic [63:0] exp_data,
  input logic finish_check,
  input logic ack,
  input logic rd_ack,
  input logic [63:0] rd_data,
  input logic [12:0] sdram_a,
  input logic [1:0] sdram_ba,
  input logic sdram_cke,
  input logic sdram_cs_l,
  input logic sdram_ras_l,
  input logic sdram_cas_l,
  input logic sdram_we_l,
  output int mismatch_count,
  output int failure_count,
  output int pending
  );

  logic [63:0] expected [$];
  int init_step, low_cycles, since_refresh;
  int reqs, acks, reads, rd_acks;
  logic req_q, last_wr, finished, late_refresh;
  logic [21:0] last_addr;

  initial
  begin
    mismatch_count = 0;
    failure_count = 0;
    pending = 0;
    finished = 1'b0;
  end

  task automatic report_mismatch(string name, logic [63:0] exp, logic [63:0] got);
    $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
    mismatch_count++;
  endtask

  task automatic report_failure(string what);
    $display("At %0t: %s", $time, what);
    failure_count++;
  endtask

  always @(negedge clk)
  begin : watch
    logic [3:0] pin_cmd;
    sdram_cmd_pkg::addr_bus_t bus;
    pin_cmd = {sdram_cs_l, sdram_ras_l, sdram_cas_l, sdram_we_l};
    bus = sdram_a;
    if (!reset_l)
    begin
      init_step = 0;
      low_cycles = 0;
      since_refresh = 0;
      {reqs, acks, reads, rd_acks} = '0;
      req_q = 1'b0;
      late_refresh = 1'b0;
    end
    else
    begin
      if (init_step < 3 && pin_cmd != sdram_cmd_pkg::nop)
      begin
        if (init_step == 1 && pin_cmd == sdram_cmd_pkg::precharge)
        begin
          if (!sdram_a[10])
            report_failure("init precharge without A10, not all banks");
          init_step = 2;
        end
        else if (init_step == 2 && pin_cmd == sdram_cmd_pkg::load_mode)
        begin
          if (bus.mode_reg.burst_length != 3'd2 || bus.mode_reg.burst_type ||
              bus.mode_reg.latency != 3'd2)
            report_failure("mode register is not burst 4, sequential, CAS latency 2");
          init_step = 3;
        end
        else
          report_failure("unexpected command before init finished");
      end
      if (init_step == 0)
      begin
        if (sdram_cke)
        begin
          if (low_cycles < sdram_timing_pkg::startup_count)
            report_failure("cke rose before the startup wait ended");
          init_step = 1;
        end
        else
          low_cycles++;
      end
      else if (init_step == 3)
      begin
        since_refresh++;
        if (pin_cmd == sdram_cmd_pkg::refresh)
          since_refresh = 0;
        if (since_refresh > sdram_timing_pkg::trefi_count + 40 && !late_refresh)
        begin
          report_failure("refresh interval exceeded");
          late_refresh = 1'b1;
        end
        if (pin_cmd == sdram_cmd_pkg::activate)
        begin
          if (sdram_a != addr[21:9])
            report_mismatch("sdram_a", 64'(addr[21:9]), 64'(sdram_a));
          if (sdram_ba != addr[1:0])
            report_mismatch("sdram_ba", 64'(addr[1:0]), 64'(sdram_ba));
        end
        if (pin_cmd == sdram_cmd_pkg::read || pin_cmd == sdram_cmd_pkg::write)
        begin
          if ((pin_cmd == sdram_cmd_pkg::write) != last_wr)
            report_failure("CAS command does not match the requested direction");
          if (sdram_a != {4'b0, last_addr[8:2], 2'b0}) // Column in A8..A2
            report_mismatch("sdram_a", 64'({4'b0, last_addr[8:2], 2'b0}), 64'(sdram_a));
          if (sdram_ba != last_addr[1:0])
            report_mismatch("sdram_ba", 64'(last_addr[1:0]), 64'(sdram_ba));
        end
      end

      if (req && !req_q)
        reqs++;
      req_q = req;
      if (ack)
      begin
        acks++;
        last_addr = addr;
        last_wr = wr;
        if (!wr)
        begin
          reads++;
          expected.push_back(exp_data);
        end
      end
      if (rd_ack)
      begin
        rd_acks++;
        if (expected.size() == 0)
          report_failure("rd_ack without an outstanding read");
        else if (rd_data != expected[0])
          report_mismatch("rd_data", expected.pop_front(), rd_data);
        else
          void'(expected.pop_front());
      end
      pending = expected.size();

      if (finish_check && !finished)
      begin
        finished = 1'b1;
        if (init_step != 3)
          report_failure("init sequence never completed");
        if (reqs != acks)
          report_failure($sformatf("%0d requests but %0d acks", reqs, acks));
        if (reads != rd_acks)
          report_failure($sformatf("%0d reads but %0d rd_acks", reads, rd_acks));
      end
    end
  end

endmodule

`default_nettype wire

// File: bench/sdram_ctrl_input.txt
# Columns: operation (W write, R read), 22-bit address in hex,
# 64-bit write data or expected read data in hex
W 000000 0123456789abcdef
W 000001 fedcba9876543210
W 0002a6 a5a5a5a55a5a5a5a
W 3ffe03 0000ffff1111eeee
W 12345c deadbeefcafef00d
R 000001 fedcba9876543210
R 000000 0123456789abcdef
R 3ffe03 0000ffff1111eeee
W 000000 1357924680aceb0d
R 12345c deadbeefcafef00d
R 0002a6 a5a5a5a55a5a5a5a
R 000000 1357924680aceb0d
W 2aaaa9 8badf00d12345678
R 2aaaa9 8badf00d12345678

// File: bench/sdram_ctrl_props.sv
// Controller handshake and spacing properties

`timescale 1ns/100ps
`default_nettype none

module sdram_ctrl_props
  (
  input logic clk,
  input logic reset_l,
  input logic ack,
  input logic rd_ack,
  input logic sdram_cs_l,
  input logic sdram_ras_l,
  input logic sdram_cas_l,
  input logic sdram_we_l
  );

  logic [3:0] pin_cmd;
  logic [7:0] since_refresh; // Cycles since the last refresh, saturating
  logic [7:0] since_activate;
  logic is_cas;

  assign pin_cmd = {sdram_cs_l, sdram_ras_l, sdram_cas_l, sdram_we_l};
  assign is_cas = (pin_cmd == sdram_cmd_pkg::read) || (pin_cmd == sdram_cmd_pkg::write);

  always_ff @(posedge clk)
  begin
    if (!reset_l)
    begin
      since_refresh <= '1;
      since_activate <= '1;
    end
    else
    begin
      if (pin_cmd == sdram_cmd_pkg::refresh)
        since_refresh <= 8'd1;
      else if (since_refresh != '1)
        since_refresh <= since_refresh + 8'd1;
      if (pin_cmd == sdram_cmd_pkg::activate)
        since_activate <= 8'd1;
      else if (since_activate != '1)
        since_activate <= since_activate + 8'd1;
    end
  end

  ack_single: assert property (@(posedge clk) disable iff (!reset_l) ack |=> !ack)
    else $error("ack high for two cycles in a row");

  rd_ack_single: assert property (@(posedge clk) disable iff (!reset_l) rd_ack |=> !rd_ack)
    else $error("rd_ack high for two cycles in a row");

  trc_spacing: assert property (@(posedge clk) disable iff (!reset_l)
    (pin_cmd == sdram_cmd_pkg::activate) |-> int'(since_refresh) >= sdram_timing_pkg::trc_count)
    else $error("activate too soon after refresh");

  trcd_spacing: assert property (@(posedge clk) disable iff (!reset_l)
    is_cas |-> int'(since_activate) >= sdram_timing_pkg::trcd_count)
    else $error("read or write too soon after activate");

endmodule

`default_nettype wire

// File: bench/sdram_ctrl_tb.sv
// SDRAM controller testbench

`timescale 1ns/100ps
`default_nettype none

module sdram_ctrl_tb;

  logic clk;
  logic reset_l;
  logic req;
  logic wr;
  logic [sdram_cmd_pkg::addr_width-1:0] addr;
  logic [sdram_cmd_pkg::client_width-1:0] wr_data;
  logic [sdram_cmd_pkg::client_width-1:0] exp_data;
  logic finish_check;
  logic ack;
  logic rd_ack;
  logic [sdram_cmd_pkg::client_width-1:0] rd_data;
  wire [sdram_cmd_pkg::dq_width-1:0] sdram_dq;
  logic [sdram_cmd_pkg::a_width-1:0] sdram_a;
  logic [sdram_cmd_pkg::ba_width-1:0] sdram_ba;
  logic sdram_cke;
  logic sdram_cs_l;
  logic sdram_ras_l;
  logic sdram_cas_l;
  logic sdram_we_l;
  int mismatch_count;
  int failure_count;
  int pending;

  // Behavioral SDRAM
  logic [15:0] mem [logic [23:0]];
  logic [12:0] open_row [4];
  logic [15:0] rd_words [$];
  int rd_wait;
  int wr_left;
  logic [23:0] wr_base;
  logic mem_oe = 1'b0;
  logic [15:0] mem_drive = '0;

  byte ops [$];
  logic [21:0] addrs [$];
  logic [63:0] datas [$];
  logic loaded;
  longint limit_ns;

  assign sdram_dq = mem_oe ? mem_drive : 16'bz;

  sdram_ctrl sdram_ctrl_inst
    (
    .clk (clk), .reset_l (reset_l), .req (req), .wr (wr), .addr (addr),
    .wr_data (wr_data), .ack (ack), .rd_ack (rd_ack), .rd_data (rd_data),
    .sdram_dq (sdram_dq), .sdram_a (sdram_a), .sdram_ba (sdram_ba),
    .sdram_cke (sdram_cke), .sdram_cs_l (sdram_cs_l), .sdram_ras_l (sdram_ras_l),
    .sdram_cas_l (sdram_cas_l), .sdram_we_l (sdram_we_l)
    );

  sdram_checker checker_inst
    (
    .clk (clk), .reset_l (reset_l), .req (req), .wr (wr), .addr (addr),
    .exp_data (exp_data), .finish_check (finish_check), .ack (ack),
    .rd_ack (rd_ack), .rd_data (rd_data), .sdram_a (sdram_a), .sdram_ba (sdram_ba),
    .sdram_cke (sdram_cke), .sdram_cs_l (sdram_cs_l), .sdram_ras_l (sdram_ras_l),
    .sdram_cas_l (sdram_cas_l), .sdram_we_l (sdram_we_l),
    .mismatch_count (mismatch_count), .failure_count (failure_count), .pending (pending)
    );

  bind sdram_ctrl sdram_ctrl_props props_inst
    (
    .clk (clk), .reset_l (reset_l), .ack (ack), .rd_ack (rd_ack),
    .sdram_cs_l (sdram_cs_l), .sdram_ras_l (sdram_ras_l),
    .sdram_cas_l (sdram_cas_l), .sdram_we_l (sdram_we_l)
    );

  function automatic logic [15:0] stored_word(logic [23:0] key);
    if (mem.exists(key))
      return mem[key];
    return key[15:0] ^ {key[23:16], key[7:0]}; // Fill for unwritten cells
  endfunction

  task automatic stop_with_failure(string reason);
    $display("%s", reason);
    $display("sim failed");
    $finish;
  endtask

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(negedge clk)
  begin : memory_model
    logic [3:0] pin_cmd;
    logic [23:0] key;
    pin_cmd = {sdram_cs_l, sdram_ras_l, sdram_cas_l, sdram_we_l};
    mem_oe <= 1'b0;
    if (rd_words.size() != 0)
    begin
      if (rd_wait > 0)
        rd_wait--;
      else
      begin
        mem_oe <= 1'b1;
        mem_drive <= rd_words.pop_front();
      end
    end
    if (pin_cmd == sdram_cmd_pkg::activate)
      open_row[sdram_ba] = sdram_a;
    else if (pin_cmd == sdram_cmd_pkg::write)
    begin
      wr_left = sdram_timing_pkg::burst_len;
      wr_base = {sdram_ba, open_row[sdram_ba], sdram_a[8:0]};
    end
    else if (pin_cmd == sdram_cmd_pkg::read)
    begin
      rd_wait = sdram_timing_pkg::cas_latency - 2; // Word 0 valid at command edge plus CL
      for (int i = 0; i < sdram_timing_pkg::burst_len; i++)
      begin
        key = {sdram_ba, open_row[sdram_ba], 9'(sdram_a[8:0] + 9'(i))};
        rd_words.push_back(stored_word(key));
      end
    end
    if (wr_left > 0)
    begin
      mem[wr_base + 24'(sdram_timing_pkg::burst_len - wr_left)] = sdram_dq;
      wr_left--;
    end
  end

  initial
  begin : watchdog
    wait (loaded);
    #(limit_ns);
    stop_with_failure("Timeout: the transactions did not complete in the allowed time");
  end

  initial
  begin : stimulus
    int fd;
    int gap;
    string line;
    byte op;
    logic [21:0] a;
    logic [63:0] d;
    req = 1'b0;
    wr = 1'b0;
    addr = '0;
    wr_data = '0;
    exp_data = '0;
    finish_check = 1'b0;
    reset_l = 1'b0;
    rd_wait = 0;
    wr_left = 0;
    loaded = 1'b0;
    void'($urandom(32'h76d0));
    fd = $fopen("bench/sdram_ctrl_input.txt", "r");
    if (fd == 0)
      stop_with_failure("Could not open bench/sdram_ctrl_input.txt");
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.getc(0) != "#")
          if ($sscanf(line, "%c %h %h", op, a, d) == 3)
          begin
            ops.push_back(op);
            addrs.push_back(a);
            datas.push_back(d);
          end
      end
      $fclose(fd);
      limit_ns = 100 * (longint'(sdram_timing_pkg::startup_count) + ops.size() * 50 + 2000);
      loaded = 1'b1;

      repeat (8) @(posedge clk);
      #10 reset_l = 1'b1;

      foreach (ops[i])
      begin
        gap = $urandom_range(0, 7);
        repeat (gap) @(posedge clk);
        @(posedge clk);
        #10;
        req = 1'b1;
        wr = (ops[i] == "W");
        addr = addrs[i];
        wr_data = (ops[i] == "W") ? datas[i] : 64'h0;
        exp_data = datas[i];
        @(negedge clk);
        while (!ack)
          @(negedge clk);
        @(posedge clk);
        #10 req = 1'b0;
      end

      while (pending != 0)
        @(posedge clk);
      // Idle long enough for two more refreshes
      repeat (2 * sdram_timing_pkg::trefi_count) @(posedge clk);
      finish_check = 1'b1;
      repeat (2) @(posedge clk);
      $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
      if (mismatch_count + failure_count == 0)
      begin
        $display("sim passed");
        $finish;
      end
      else
        stop_with_failure("One or more checks failed");
    end
  end

endmodule

`default_nettype wire

// File: compile.f
source/sdram_timing_pkg.sv
source/sdram_cmd_pkg.sv
source/sdram_cmd_if.sv
source/sdram_sequencer.sv
source/sdram_data_path.sv
source/sdram_pads.sv
source/sdram_ctrl.sv
bench/sdram_ctrl_props.sv
bench/sdram_checker.sv
bench/sdram_ctrl_tb.sv

// File: source/sdram_cmd_if.sv
// SDRAM command bus

`timescale 1ns/100ps
`default_nettype none

interface sdram_cmd_if;

  // Next-cycle pin values
  sdram_cmd_pkg::cmd_t cmd;
  sdram_cmd_pkg::addr_bus_t a;
  logic [sdram_cmd_pkg::ba_width-1:0] ba;
  logic cke;

  modport sequencer (output cmd, a, ba, cke);

  modport pads (input cmd, a, ba, cke);

endinterface

`default_nettype wire

// File: source/sdram_cmd_pkg.sv
// SDRAM command and address types

`default_nettype none

package sdram_cmd_pkg;

  localparam int dq_width = 16;
  localparam int client_width = 64;
  localparam int addr_width = 22;
  localparam int a_width = 13;
  localparam int ba_width = 2;

  // Client address is row[21:9], col[8:2], bank[1:0]
  localparam int row_lsb = 9;
  localparam int row_width = 13;
  localparam int col_lsb = 2;
  localparam int col_width = 7;
  localparam int bank_lsb = 0;

  localparam int ap_bit = 10; // Auto-precharge, all banks on precharge

  // Encoded as {cs_l, ras_l, cas_l, we_l}
  typedef enum logic [3:0] {
    nop       = 4'b0111,
    activate  = 4'b0011,
    read      = 4'b0101,
    write     = 4'b0100,
    precharge = 4'b0010,
    refresh   = 4'b0001,
    load_mode = 4'b0000
  } cmd_t;

  typedef enum logic [2:0] {
    reset,
    startup,
    mode,
    idle,
    cas,
    pre
  } seq_state_t;

  typedef struct packed {
    logic [2:0] unused;
    logic write_burst; // 0 for burst writes
    logic [1:0] test_mode;
    logic [2:0] latency;
    logic burst_type; // 0 for sequential
    logic [2:0] burst_length; // log2 of words
  } mode_reg_t;

  typedef logic [a_width-1:0] row_col_t;

  // A bus seen as mode register or as row / column word
  typedef union packed {
    mode_reg_t mode_reg;
    row_col_t row_col;
  } addr_bus_t;

endpackage

`default_nettype wire

// File: source/sdram_ctrl.sv
// SDRAM controller top

`timescale 1ns/100ps
`default_nettype none

module sdram_ctrl
  (
  input logic clk,
  input logic reset_l,
  input logic req, // Level or pulse, latched until ack
  input logic wr,
  input logic [sdram_cmd_pkg::addr_width-1:0] addr,
  input logic [sdram_cmd_pkg::client_width-1:0] wr_data,
  output logic ack,
  output logic rd_ack,
  output logic [sdram_cmd_pkg::client_width-1:0] rd_data,
  inout wire [sdram_cmd_pkg::dq_width-1:0] sdram_dq,
  output logic [sdram_cmd_pkg::a_width-1:0] sdram_a,
  output logic [sdram_cmd_pkg::ba_width-1:0] sdram_ba,
  output logic sdram_cke,
  output logic sdram_cs_l,
  output logic sdram_ras_l,
  output logic sdram_cas_l,
  output logic sdram_we_l
  );

  logic wr_start;
  logic rd_start;
  logic [sdram_cmd_pkg::dq_width-1:0] dq_out;
  logic dq_oe;
  logic [sdram_cmd_pkg::dq_width-1:0] dq_in;

  sdram_cmd_if cmd_bus ();

  sdram_sequencer sequencer_inst
    (
    .clk (clk),
    .reset_l (reset_l),
    .req (req),
    .wr (wr),
    .addr (addr),
    .cmd_port (cmd_bus.sequencer),
    .wr_start (wr_start),
    .rd_start (rd_start),
    .ack (ack)
    );

  sdram_data_path data_path_inst
    (
    .clk (clk),
    .reset_l (reset_l),
    .wr_start (wr_start),
    .rd_start (rd_start),
    .wr_data (wr_data),
    .dq_in (dq_in),
    .dq_out (dq_out),
    .dq_oe (dq_oe),
    .rd_data (rd_data),
    .rd_ack (rd_ack)
    );

  sdram_pads pads_inst
    (
    .clk (clk),
    .cmd_port (cmd_bus.pads),
    .dq_out (dq_out),
    .dq_oe (dq_oe),
    .dq_in (dq_in),
    .sdram_dq (sdram_dq),
    .sdram_a (sdram_a),
    .sdram_ba (sdram_ba),
    .sdram_cke (sdram_cke),
    .sdram_cs_l (sdram_cs_l),
    .sdram_ras_l (sdram_ras_l),
    .sdram_cas_l (sdram_cas_l),
    .sdram_we_l (sdram_we_l)
    );

endmodule

`default_nettype wire

// File: source/sdram_data_path.sv
// SDRAM write serializer and read capture

`timescale 1ns/100ps
`default_nettype none

module sdram_data_path
  (
  input logic clk,
  input logic reset_l,
  input logic wr_start,
  input logic rd_start,
  input logic [sdram_cmd_pkg::client_width-1:0] wr_data,
  input logic [sdram_cmd_pkg::dq_width-1:0] dq_in,
  output logic [sdram_cmd_pkg::dq_width-1:0] dq_out,
  output logic dq_oe,
  output logic [sdram_cmd_pkg::client_width-1:0] rd_data,
  output logic rd_ack
  );

  logic [sdram_cmd_pkg::client_width-sdram_cmd_pkg::dq_width-1:0] shift_out;
  logic [$clog2(sdram_timing_pkg::burst_len)-1:0] shift_count; // Words left after this one
  logic [sdram_timing_pkg::read_ack_delay-1:0] rd_pipe;
  logic [sdram_cmd_pkg::client_width-sdram_cmd_pkg::dq_width-1:0] collector;

  // First word leaves with the write command, MSW first
  assign dq_out = wr_start ?
    wr_data[sdram_cmd_pkg::client_width-1 -: sdram_cmd_pkg::dq_width] :
    shift_out[sdram_cmd_pkg::client_width-sdram_cmd_pkg::dq_width-1 -: sdram_cmd_pkg::dq_width];

  assign dq_oe = wr_start || (shift_count != '0);

  always_ff @(posedge clk)
  begin
    if (!reset_l)
    begin
      shift_count <= '0;
      rd_pipe <= '0;
      rd_ack <= 1'b0;
    end
    else
    begin
      if (wr_start)
        shift_count <= '1; // Rest of the burst
      else if (shift_count != '0)
        shift_count <= shift_count - 1'b1;
      rd_pipe <= {rd_pipe[sdram_timing_pkg::read_ack_delay-2:0], rd_start};
      rd_ack <= rd_pipe[sdram_timing_pkg::read_ack_delay-1];
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_start)
      shift_out <= wr_data[sdram_cmd_pkg::client_width-sdram_cmd_pkg::dq_width-1:0];
    else
      shift_out <= shift_out << sdram_cmd_pkg::dq_width;

    // Oldest word ends up on top
    collector <= {collector[sdram_cmd_pkg::client_width-2*sdram_cmd_pkg::dq_width-1:0], dq_in};

    if (rd_pipe[sdram_timing_pkg::read_ack_delay-1])
      rd_data <= {collector, dq_in}; // Last word still on dq_in
  end

endmodule

`default_nettype wire

// File: source/sdram_pads.sv
// SDRAM pin registers

`timescale 1ns/100ps
`default_nettype none

module sdram_pads
  (
  input logic clk,
  sdram_cmd_if.pads cmd_port,
  input logic [sdram_cmd_pkg::dq_width-1:0] dq_out,
  input logic dq_oe,
  output logic [sdram_cmd_pkg::dq_width-1:0] dq_in,
  inout wire [sdram_cmd_pkg::dq_width-1:0] sdram_dq,
  output logic [sdram_cmd_pkg::a_width-1:0] sdram_a,
  output logic [sdram_cmd_pkg::ba_width-1:0] sdram_ba,
  output logic sdram_cke,
  output logic sdram_cs_l,
  output logic sdram_ras_l,
  output logic sdram_cas_l,
  output logic sdram_we_l
  );

  logic [sdram_cmd_pkg::dq_width-1:0] dq_q;
  logic [sdram_cmd_pkg::dq_width-1:0] oe_q; // One enable flop per pin

  always_ff @(posedge clk)
  begin
    {sdram_cs_l, sdram_ras_l, sdram_cas_l, sdram_we_l} <= cmd_port.cmd;
    sdram_a <= cmd_port.a;
    sdram_ba <= cmd_port.ba;
    sdram_cke <= cmd_port.cke;
    dq_q <= dq_out;
    oe_q <= {sdram_cmd_pkg::dq_width{dq_oe}};
    dq_in <= sdram_dq; // Input side
  end

  for (genvar i = 0; i < sdram_cmd_pkg::dq_width; i++)
  begin : dq_pin
    assign sdram_dq[i] = oe_q[i] ? dq_q[i] : 1'bz;
  end

endmodule

`default_nettype wire

// File: source/sdram_sequencer.sv
// SDRAM command sequencer

`timescale 1ns/100ps
`default_nettype none

module sdram_sequencer
  (
  input logic clk,
  input logic reset_l,
  input logic req,
  input logic wr,
  input logic [sdram_cmd_pkg::addr_width-1:0] addr,
  sdram_cmd_if.sequencer cmd_port,
  output logic wr_start,
  output logic rd_start,
  output logic ack
  );

  sdram_cmd_pkg::seq_state_t state, ns_state;
  logic [15:0] count, ns_count;
  logic [11:0] refresh_count, ns_refresh_count; // Bit 11 set when refresh is due
  logic req_hold, ns_req_hold;
  logic cke_hold, ns_cke;
  sdram_cmd_pkg::addr_bus_t a_hold, ns_a;
  logic [sdram_cmd_pkg::ba_width-1:0] ba_hold, ns_ba;
  sdram_cmd_pkg::cmd_t ns_cmd;

  always_ff @(posedge clk)
  begin
    if (!reset_l)
    begin
      state <= sdram_cmd_pkg::reset;
      count <= 16'(sdram_timing_pkg::startup_count);
      refresh_count <= '0;
      req_hold <= 1'b0;
      cke_hold <= 1'b0;
    end
    else
    begin
      state <= ns_state;
      count <= ns_count;
      refresh_count <= ns_refresh_count;
      req_hold <= ns_req_hold;
      cke_hold <= ns_cke;
    end
  end

  always_ff @(posedge clk)
  begin
    a_hold <= ns_a;
    ba_hold <= ns_ba;
  end

  always_comb
  begin
    ns_cmd = sdram_cmd_pkg::nop;
    ns_state = state;
    ns_count = count;
    ns_refresh_count = refresh_count - 12'd1;
    ns_req_hold = req_hold | req;
    ns_cke = cke_hold;
    ns_a = a_hold;
    ns_ba = ba_hold;
    ack = 1'b0;
    wr_start = 1'b0;
    rd_start = 1'b0;

    if (count != 16'd0)
      ns_count = count - 16'd1;

    case (state)
      sdram_cmd_pkg::reset:
      begin
        ns_refresh_count = '1; // First refresh right after init
        if (count == 16'd0)
        begin
          ns_cke = 1'b1;
          ns_state = sdram_cmd_pkg::startup;
        end
      end

      sdram_cmd_pkg::startup:
      begin
        ns_cmd = sdram_cmd_pkg::precharge; // All banks
        ns_a.row_col = '0;
        ns_a.row_col[sdram_cmd_pkg::ap_bit] = 1'b1;
        ns_ba = '0;
        ns_count = 16'(sdram_timing_pkg::trp_count - 1);
        ns_state = sdram_cmd_pkg::mode;
      end

      sdram_cmd_pkg::mode:
        if (count == 16'd0)
        begin
          ns_cmd = sdram_cmd_pkg::load_mode;
          ns_ba = '0;
          ns_a.mode_reg.unused = '0;
          ns_a.mode_reg.write_burst = 1'b0;
          ns_a.mode_reg.test_mode = '0;
          ns_a.mode_reg.latency = 3'(sdram_timing_pkg::cas_latency);
          ns_a.mode_reg.burst_type = 1'b0;
          ns_a.mode_reg.burst_length = 3'($clog2(sdram_timing_pkg::burst_len));
          ns_count = 16'(sdram_timing_pkg::tmrd_count - 1);
          ns_state = sdram_cmd_pkg::idle;
        end

      sdram_cmd_pkg::idle:
        if (count == 16'd0)
        begin
          if (refresh_count[11])
          begin
            // All banks closed in idle
            ns_cmd = sdram_cmd_pkg::refresh;
            ns_refresh_count = refresh_count + 12'(sdram_timing_pkg::trefi_count);
            ns_count = 16'(sdram_timing_pkg::trc_count - 1);
          end
          else if (req || req_hold)
          begin
            ns_cmd = sdram_cmd_pkg::activate;
            ns_a.row_col = addr[sdram_cmd_pkg::row_lsb +: sdram_cmd_pkg::row_width];
            ns_ba = addr[sdram_cmd_pkg::bank_lsb +: sdram_cmd_pkg::ba_width];
            ns_count = 16'(sdram_timing_pkg::trcd_count - 1);
            ns_state = sdram_cmd_pkg::cas;
          end
        end

      sdram_cmd_pkg::cas:
        if (count == 16'd0)
        begin
          ack = 1'b1;
          ns_req_hold = 1'b0;
          ns_a.row_col = '0; // No auto-precharge
          ns_a.row_col[sdram_cmd_pkg::col_lsb +: sdram_cmd_pkg::col_width] =
            addr[sdram_cmd_pkg::col_lsb +: sdram_cmd_pkg::col_width];
          ns_state = sdram_cmd_pkg::pre;
          if (wr)
          begin
            ns_cmd = sdram_cmd_pkg::write;
            wr_start = 1'b1;
            ns_count = 16'(sdram_timing_pkg::write_to_pre - 1);
          end
          else
          begin
            ns_cmd = sdram_cmd_pkg::read;
            rd_start = 1'b1;
            ns_count = 16'(sdram_timing_pkg::read_to_pre - 1);
          end
        end

      sdram_cmd_pkg::pre:
        if (count == 16'd0)
        begin
          ns_cmd = sdram_cmd_pkg::precharge; // Open bank only
          ns_a.row_col[sdram_cmd_pkg::ap_bit] = 1'b0;
          ns_count = 16'(sdram_timing_pkg::trp_count - 1);
          ns_state = sdram_cmd_pkg::idle;
        end

      default:
        ns_state = sdram_cmd_pkg::reset;
    endcase
  end

  assign cmd_port.cmd = ns_cmd;
  assign cmd_port.a = ns_a;
  assign cmd_port.ba = ns_ba;
  assign cmd_port.cke = ns_cke;

endmodule

`default_nettype wire

// File: source/sdram_timing_pkg.sv
// SDRAM timing constants

`default_nettype none

package sdram_timing_pkg;

  localparam int t_cycle_ns = 8; // 125 MHz
  localparam int burst_len = 4;
  localparam int cas_latency = 2;

  // Stable inputs before cke rises
  localparam int startup_count = 65535;

  // Datasheet delays in ns, rounded up to whole cycles
  localparam int trc_count = (127 + t_cycle_ns - 1) / t_cycle_ns;
  localparam int trp_count = (21 + t_cycle_ns - 1) / t_cycle_ns;
  localparam int trcd_count = (21 + t_cycle_ns - 1) / t_cycle_ns;
  localparam int tmrd_count = (14 + t_cycle_ns - 1) / t_cycle_ns;
  localparam int trefi_count = (7800 + t_cycle_ns - 1) / t_cycle_ns;
  localparam int twr_count = (14 + t_cycle_ns - 1) / t_cycle_ns;

  // CAS command to precharge
  localparam int write_to_pre = burst_len - 1 + twr_count;
  localparam int read_to_pre = burst_len;

  // Read command on the pins until rd_ack
  // Last word is registered cas_latency + burst_len - 1 cycles after the command
  localparam int read_ack_delay = cas_latency + burst_len;

endpackage

`default_nettype wire
